// File: rtl/dec_pkg.sv
`default_nettype none

package dec_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths and fixed indices
   //////////////////////////////////////////////////////////////////////

   localparam int GRLEN     = 32;
   localparam int REG_IDX_W = 5;
   localparam int CSR_IDX_W = 14;
   localparam int EXCCODE_W = 6;

   typedef logic [GRLEN-1:0]     word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [CSR_IDX_W-1:0] csr_idx_t;

   // link register written by bl
   localparam reg_idx_t RA_IDX = 5'd1;

   //////////////////////////////////////////////////////////////////////
   // opcode match values, each sized to the field it is compared with
   //////////////////////////////////////////////////////////////////////

   // 3R format, inst[31:15]
   localparam logic [16:0] OPC_ADD_W     = 17'h00020;
   localparam logic [16:0] OPC_SUB_W     = 17'h00022;
   localparam logic [16:0] OPC_SLT       = 17'h00024;
   localparam logic [16:0] OPC_SLTU      = 17'h00025;
   localparam logic [16:0] OPC_AND       = 17'h00029;
   localparam logic [16:0] OPC_OR        = 17'h0002a;
   localparam logic [16:0] OPC_XOR       = 17'h0002b;
   localparam logic [16:0] OPC_MUL_W     = 17'h00038;
   localparam logic [16:0] OPC_MULH_W    = 17'h00039;
   localparam logic [16:0] OPC_MULH_WU   = 17'h0003a;
   localparam logic [16:0] OPC_BREAK     = 17'h00054;
   localparam logic [16:0] OPC_SYSCALL   = 17'h00056;
   // 2RI12 format, inst[31:22]
   localparam logic [9:0]  OPC_ADDI_W    = 10'h00a;
   localparam logic [9:0]  OPC_ANDI      = 10'h00d;
   localparam logic [9:0]  OPC_ORI       = 10'h00e;
   localparam logic [9:0]  OPC_LD_W      = 10'h0a2;
   localparam logic [9:0]  OPC_LD_BU     = 10'h0a8;
   localparam logic [9:0]  OPC_ST_W      = 10'h0a6;
   localparam logic [9:0]  OPC_ST_B      = 10'h0a4;
   // 1RI20 format, inst[31:25]
   localparam logic [6:0]  OPC_LU12I_W   = 7'h0a;
   localparam logic [6:0]  OPC_PCADDU12I = 7'h0e;
   // branch formats, inst[31:26]
   localparam logic [5:0]  OPC_BEQ       = 6'h16;
   localparam logic [5:0]  OPC_BNE       = 6'h17;
   localparam logic [5:0]  OPC_B         = 6'h14;
   localparam logic [5:0]  OPC_BL        = 6'h15;
   // csr group on inst[31:24], ertn is a whole word
   localparam logic [7:0]  OPC_CSR       = 8'h04;
   localparam word_t       OPC_ERTN      = 32'h06483800;

   //////////////////////////////////////////////////////////////////////
   // enums
   //////////////////////////////////////////////////////////////////////

   // codes are dense, UNIT_INE is the highest
   typedef enum logic [3:0] {
      UNIT_ALU, UNIT_LSU, UNIT_BRU, UNIT_MUL, UNIT_CSR,
      UNIT_ERTN, UNIT_SYSCALL, UNIT_BREAK, UNIT_INE
   } unit_e;

   typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLT, SLTU, LUI} alu_op_e;
   typedef enum logic [1:0] {LD_W, LD_BU, ST_W, ST_B} lsu_op_e;
   typedef enum logic [1:0] {BEQ, BNE, B, BL} bru_op_e;
   typedef enum logic [1:0] {MUL_W, MULH_W, MULH_WU} mul_op_e;
   typedef enum logic [2:0] {NONE, SI12, UI12, SI20, OFFS16, OFFS26} imm_kind_e;
   typedef enum logic [1:0] {CSR_RD, CSR_WR, CSR_XCHG} csr_op_e;

   typedef enum logic [EXCCODE_W-1:0] {
      EXC_NONE = 6'h00,
      EXC_SYS  = 6'h0b,
      EXC_BRK  = 6'h0c,
      EXC_INE  = 6'h0d
   } exccode_e;

   //////////////////////////////////////////////////////////////////////
   // structs passed between the blocks
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      unit_e     unit;
      alu_op_e   alu_op;
      lsu_op_e   lsu_op;
      bru_op_e   bru_op;
      mul_op_e   mul_op;
      csr_op_e   csr_op;
      imm_kind_e imm_kind;
      logic      pc_src;
      logic      rd_read;
      logic      gr_wen;
   } dec_ctl_t;

   typedef struct packed {
      reg_idx_t rs1;
      reg_idx_t rs2;
   } rs_idx_t;

   typedef struct packed {
      word_t   a;
      word_t   b;
      alu_op_e op;
      logic    b_imm;
      logic    wen;
   } alu_ctl_t;

   typedef struct packed {
      logic     valid;
      lsu_op_e  op;
      word_t    imm_shifted;
      reg_idx_t rd;
      logic     wen;
   } lsu_ctl_t;

   typedef struct packed {
      logic    valid;
      bru_op_e op;
      word_t   offset;
   } bru_ctl_t;

   typedef struct packed {
      logic valid;
      logic wen;
      logic is_signed;
      logic hi;
   } mul_ctl_t;

   typedef struct packed {
      logic     valid;
      logic     rdwen;
      logic     xchg;
      logic     wen;
      csr_idx_t waddr;
   } csr_ctl_t;

   typedef struct packed {
      logic     exception;
      exccode_e exccode;
   } exc_ctl_t;

   typedef struct packed {
      alu_ctl_t alu;
      lsu_ctl_t lsu;
      bru_ctl_t bru;
      mul_ctl_t mul;
      csr_ctl_t csr;
      exc_ctl_t exc;
      rs_idx_t  rs_idx;
      reg_idx_t rf_target;
      logic     ertn_valid;
   } d2e_t;

endpackage

`default_nettype wire

// File: rtl/inst_decoder.sv
`default_nettype none

module inst_decoder (
   input  dec_pkg::word_t    inst,
   output dec_pkg::dec_ctl_t ctl
);

   //////////////////////////////////////////////////////////////////////
   // per-class control builders
   //////////////////////////////////////////////////////////////////////

   function automatic dec_pkg::dec_ctl_t alu_ctl(input dec_pkg::alu_op_e   op,
                                                  input dec_pkg::imm_kind_e kind,
                                                  input logic              pc_src);
      dec_pkg::dec_ctl_t c;
      c          = '0;
      c.unit     = dec_pkg::UNIT_ALU;
      c.alu_op   = op;
      c.imm_kind = kind;
      c.pc_src   = pc_src;
      c.gr_wen   = 1'b1;
      return c;
   endfunction

   function automatic dec_pkg::dec_ctl_t lsu_ctl(input dec_pkg::lsu_op_e op);
      dec_pkg::dec_ctl_t c;
      logic              store;
      store      = (op == dec_pkg::ST_W) || (op == dec_pkg::ST_B);
      c          = '0;
      c.unit     = dec_pkg::UNIT_LSU;
      c.lsu_op   = op;
      c.imm_kind = dec_pkg::SI12;
      // store data comes in through the rd field
      c.rd_read  = store;
      c.gr_wen   = !store;
      return c;
   endfunction

   function automatic dec_pkg::dec_ctl_t bru_ctl(input dec_pkg::bru_op_e op);
      dec_pkg::dec_ctl_t c;
      logic              cond;
      cond       = (op == dec_pkg::BEQ) || (op == dec_pkg::BNE);
      c          = '0;
      c.unit     = dec_pkg::UNIT_BRU;
      c.bru_op   = op;
      c.imm_kind = cond ? dec_pkg::OFFS16 : dec_pkg::OFFS26;
      // compare rj against rd
      c.rd_read  = cond;
      c.gr_wen   = (op == dec_pkg::BL);
      return c;
   endfunction

   function automatic dec_pkg::dec_ctl_t mul_ctl(input dec_pkg::mul_op_e op);
      dec_pkg::dec_ctl_t c;
      c        = '0;
      c.unit   = dec_pkg::UNIT_MUL;
      c.mul_op = op;
      c.gr_wen = 1'b1;
      return c;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // opcode match, formats do not overlap
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      ctl      = '0;
      ctl.unit = dec_pkg::UNIT_INE;

      case (inst[31:15])
         dec_pkg::OPC_ADD_W:   ctl = alu_ctl(dec_pkg::ADD, dec_pkg::NONE, 1'b0);
         dec_pkg::OPC_SUB_W:   ctl = alu_ctl(dec_pkg::SUB, dec_pkg::NONE, 1'b0);
         dec_pkg::OPC_SLT:     ctl = alu_ctl(dec_pkg::SLT, dec_pkg::NONE, 1'b0);
         dec_pkg::OPC_SLTU:    ctl = alu_ctl(dec_pkg::SLTU, dec_pkg::NONE, 1'b0);
         dec_pkg::OPC_AND:     ctl = alu_ctl(dec_pkg::AND, dec_pkg::NONE, 1'b0);
         dec_pkg::OPC_OR:      ctl = alu_ctl(dec_pkg::OR, dec_pkg::NONE, 1'b0);
         dec_pkg::OPC_XOR:     ctl = alu_ctl(dec_pkg::XOR, dec_pkg::NONE, 1'b0);
         dec_pkg::OPC_MUL_W:   ctl = mul_ctl(dec_pkg::MUL_W);
         dec_pkg::OPC_MULH_W:  ctl = mul_ctl(dec_pkg::MULH_W);
         dec_pkg::OPC_MULH_WU: ctl = mul_ctl(dec_pkg::MULH_WU);
         dec_pkg::OPC_SYSCALL: ctl.unit = dec_pkg::UNIT_SYSCALL;
         dec_pkg::OPC_BREAK:   ctl.unit = dec_pkg::UNIT_BREAK;
         default: ;
      endcase

      case (inst[31:22])
         dec_pkg::OPC_ADDI_W: ctl = alu_ctl(dec_pkg::ADD, dec_pkg::SI12, 1'b0);
         dec_pkg::OPC_ANDI:   ctl = alu_ctl(dec_pkg::AND, dec_pkg::UI12, 1'b0);
         dec_pkg::OPC_ORI:    ctl = alu_ctl(dec_pkg::OR, dec_pkg::UI12, 1'b0);
         dec_pkg::OPC_LD_W:   ctl = lsu_ctl(dec_pkg::LD_W);
         dec_pkg::OPC_LD_BU:  ctl = lsu_ctl(dec_pkg::LD_BU);
         dec_pkg::OPC_ST_W:   ctl = lsu_ctl(dec_pkg::ST_W);
         dec_pkg::OPC_ST_B:   ctl = lsu_ctl(dec_pkg::ST_B);
         default: ;
      endcase

      // lu12i.w passes B through, pcaddu12i adds it to the pc
      case (inst[31:25])
         dec_pkg::OPC_LU12I_W:   ctl = alu_ctl(dec_pkg::LUI, dec_pkg::SI20, 1'b0);
         dec_pkg::OPC_PCADDU12I: ctl = alu_ctl(dec_pkg::ADD, dec_pkg::SI20, 1'b1);
         default: ;
      endcase

      case (inst[31:26])
         dec_pkg::OPC_BEQ: ctl = bru_ctl(dec_pkg::BEQ);
         dec_pkg::OPC_BNE: ctl = bru_ctl(dec_pkg::BNE);
         dec_pkg::OPC_B:   ctl = bru_ctl(dec_pkg::B);
         dec_pkg::OPC_BL:  ctl = bru_ctl(dec_pkg::BL);
         default: ;
      endcase

      if (inst[31:24] == dec_pkg::OPC_CSR) begin
         ctl.unit   = dec_pkg::UNIT_CSR;
         ctl.gr_wen = 1'b1;
         // rj picks read, write or exchange
         case (inst[9:5])
            5'd0:    ctl.csr_op = dec_pkg::CSR_RD;
            5'd1:    ctl.csr_op = dec_pkg::CSR_WR;
            default: ctl.csr_op = dec_pkg::CSR_XCHG;
         endcase
         ctl.rd_read = (inst[9:5] != 5'd0);
      end

      if (inst == dec_pkg::OPC_ERTN) begin
         ctl.unit = dec_pkg::UNIT_ERTN;
      end
   end

   // a known word always lands on a defined class
   always_comb begin
      if (!$isunknown(inst)) begin
         assert (ctl.unit <= dec_pkg::UNIT_INE)
            else $error("decoder produced an undefined unit class");
      end
   end

endmodule

`default_nettype wire

// File: rtl/imm_gen.sv
`default_nettype none

module imm_gen (
   input  dec_pkg::word_t     inst,
   input  dec_pkg::imm_kind_e kind,
   output dec_pkg::word_t     imm_shifted,
   output dec_pkg::word_t     br_offs
);

   // all immediate shifting and extension happens here
   always_comb begin
      imm_shifted = '0;
      br_offs     = '0;

      case (kind)
         dec_pkg::SI12: begin
            imm_shifted = {{20{inst[21]}}, inst[21:10]};
         end
         dec_pkg::UI12: begin
            imm_shifted = {20'b0, inst[21:10]};
         end
         // upper immediate lands in bits 31:12
         dec_pkg::SI20: begin
            imm_shifted = {inst[24:5], 12'b0};
         end
         // word offsets, so the low two bits are zero
         dec_pkg::OFFS16: begin
            br_offs = {{14{inst[25]}}, inst[25:10], 2'b00};
         end
         dec_pkg::OFFS26: begin
            // high part sits in inst[9:0]
            br_offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/dispatch_ctrl.sv
`default_nettype none

module dispatch_ctrl (
   input  dec_pkg::dec_ctl_t ctl,
   input  dec_pkg::word_t    inst,
   input  dec_pkg::word_t    pc,
   input  logic              inst_vld,
   input  dec_pkg::word_t    rs1_data,
   input  dec_pkg::word_t    rs2_data,
   input  dec_pkg::word_t    imm_shifted,
   input  dec_pkg::word_t    br_offs,
   output dec_pkg::rs_idx_t  rs_idx,
   output dec_pkg::d2e_t     d2e
);

   dec_pkg::exccode_e exccode;
   logic              exception;
   logic              dispatch_ok;
   logic              alu_disp;
   logic              lsu_disp;
   logic              bru_disp;
   logic              mul_disp;
   logic              csr_disp;
   logic              ertn_disp;
   logic              b_imm;
   dec_pkg::reg_idx_t rf_target;

   //////////////////////////////////////////////////////////////////////
   // exceptions, syscall over break over illegal
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      exccode = dec_pkg::EXC_NONE;
      if (inst_vld) begin
         if (ctl.unit == dec_pkg::UNIT_SYSCALL) begin
            exccode = dec_pkg::EXC_SYS;
         end else if (ctl.unit == dec_pkg::UNIT_BREAK) begin
            exccode = dec_pkg::EXC_BRK;
         end else if (ctl.unit == dec_pkg::UNIT_INE) begin
            exccode = dec_pkg::EXC_INE;
         end
      end
   end

   assign exception = (exccode != dec_pkg::EXC_NONE);

   //////////////////////////////////////////////////////////////////////
   // dispatch, nothing leaves on a killed or trapping slot
   //////////////////////////////////////////////////////////////////////

   assign dispatch_ok = inst_vld & ~exception;
   assign alu_disp    = dispatch_ok & (ctl.unit == dec_pkg::UNIT_ALU);
   assign lsu_disp    = dispatch_ok & (ctl.unit == dec_pkg::UNIT_LSU);
   assign bru_disp    = dispatch_ok & (ctl.unit == dec_pkg::UNIT_BRU);
   assign mul_disp    = dispatch_ok & (ctl.unit == dec_pkg::UNIT_MUL);
   assign csr_disp    = dispatch_ok & (ctl.unit == dec_pkg::UNIT_CSR);
   assign ertn_disp   = dispatch_ok & (ctl.unit == dec_pkg::UNIT_ERTN);

   assign b_imm = alu_disp & (ctl.imm_kind != dec_pkg::NONE);

   // bl links through r1
   assign rf_target = (ctl.unit == dec_pkg::UNIT_BRU && ctl.bru_op == dec_pkg::BL) ?
                      dec_pkg::RA_IDX : inst[4:0];

   assign rs_idx.rs1 = inst[9:5];
   assign rs_idx.rs2 = ctl.rd_read ? inst[4:0] : inst[14:10];

   always_comb begin
      d2e.alu.a           = ctl.pc_src ? pc : rs1_data;
      d2e.alu.b           = b_imm ? imm_shifted : rs2_data;
      d2e.alu.op          = ctl.alu_op;
      d2e.alu.b_imm       = b_imm;
      d2e.alu.wen         = ctl.gr_wen & alu_disp;

      d2e.lsu.valid       = lsu_disp;
      d2e.lsu.op          = ctl.lsu_op;
      d2e.lsu.imm_shifted = imm_shifted;
      d2e.lsu.rd          = rf_target;
      d2e.lsu.wen         = ctl.gr_wen & lsu_disp;

      d2e.bru.valid       = bru_disp;
      d2e.bru.op          = ctl.bru_op;
      d2e.bru.offset      = br_offs;

      d2e.mul.valid       = mul_disp;
      d2e.mul.wen         = ctl.gr_wen & mul_disp;
      d2e.mul.is_signed   = (ctl.mul_op == dec_pkg::MUL_W) || (ctl.mul_op == dec_pkg::MULH_W);
      d2e.mul.hi          = (ctl.mul_op == dec_pkg::MULH_W) || (ctl.mul_op == dec_pkg::MULH_WU);

      // csrrd only reads, wr and xchg also update the csr
      d2e.csr.valid       = csr_disp;
      d2e.csr.rdwen       = ctl.gr_wen & csr_disp;
      d2e.csr.xchg        = csr_disp & (ctl.csr_op == dec_pkg::CSR_XCHG);
      d2e.csr.wen         = csr_disp & (ctl.csr_op != dec_pkg::CSR_RD);
      d2e.csr.waddr       = inst[23:10];

      d2e.exc.exception   = exception;
      d2e.exc.exccode     = exccode;

      d2e.rs_idx          = rs_idx;
      d2e.rf_target       = rf_target;
      d2e.ertn_valid      = ertn_disp;
   end

   // one destination per instruction
   always_comb begin
      assert ($onehot0({alu_disp, lsu_disp, bru_disp, mul_disp, csr_disp,
                        ertn_disp, exception}))
         else $error("more than one dispatch target in decode");
   end

endmodule

`default_nettype wire

// File: rtl/d2e_reg.sv
`default_nettype none

module d2e_reg (
   input  logic          clk,
   input  logic          rst,
   input  dec_pkg::d2e_t d,
   output dec_pkg::d2e_t q
);

   //////////////////////////////////////////////////////////////////////
   // decode to execute stage
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      q <= d;
      // qualifier bits clear on reset
      if (rst) begin
         q.alu.b_imm     <= 1'b0;
         q.alu.wen       <= 1'b0;
         q.lsu.valid     <= 1'b0;
         q.lsu.wen       <= 1'b0;
         q.bru.valid     <= 1'b0;
         q.mul.valid     <= 1'b0;
         q.mul.wen       <= 1'b0;
         q.csr.valid     <= 1'b0;
         q.csr.rdwen     <= 1'b0;
         q.csr.xchg      <= 1'b0;
         q.csr.wen       <= 1'b0;
         q.exc.exception <= 1'b0;
         q.ertn_valid    <= 1'b0;
      end
   end

   // a trapped instruction must not reach any unit in execute
   a_exc_no_unit: assert property (
      @(posedge clk) disable iff (rst)
      q.exc.exception |-> !(q.alu.wen || q.lsu.valid || q.bru.valid ||
                            q.mul.valid || q.csr.valid || q.ertn_valid)
   ) else $error("exception and unit valid both set in execute");

endmodule

`default_nettype wire

// File: rtl/ifu_dec.sv
`default_nettype none

module ifu_dec (
   input  logic              clk,
   input  logic              rst,
   input  dec_pkg::word_t    inst_d,
   input  dec_pkg::word_t    pc_d,
   input  logic              inst_vld_d,
   input  dec_pkg::word_t    rs1_data_d,
   input  dec_pkg::word_t    rs2_data_d,
   output dec_pkg::rs_idx_t  rs_idx_d,
   output dec_pkg::csr_idx_t csr_raddr_d,
   output dec_pkg::d2e_t     ex_e
);

   dec_pkg::dec_ctl_t ctl_d;
   dec_pkg::word_t    imm_shifted_d;
   dec_pkg::word_t    br_offs_d;
   dec_pkg::d2e_t     d2e_d;

   inst_decoder u_decoder (
      .inst (inst_d),
      .ctl  (ctl_d)
   );

   imm_gen u_imm (
      .inst        (inst_d),
      .kind        (ctl_d.imm_kind),
      .imm_shifted (imm_shifted_d),
      .br_offs     (br_offs_d)
   );

   dispatch_ctrl u_dispatch (
      .ctl         (ctl_d),
      .inst        (inst_d),
      .pc          (pc_d),
      .inst_vld    (inst_vld_d),
      .rs1_data    (rs1_data_d),
      .rs2_data    (rs2_data_d),
      .imm_shifted (imm_shifted_d),
      .br_offs     (br_offs_d),
      .rs_idx      (rs_idx_d),
      .d2e         (d2e_d)
   );

   d2e_reg u_d2e (
      .clk (clk),
      .rst (rst),
      .d   (d2e_d),
      .q   (ex_e)
   );

   // csr read port is looked up in decode
   assign csr_raddr_d = inst_d[23:10];

endmodule

`default_nettype wire

// File: include/ifu_dec_vectors.svh
`ifndef IFU_DEC_VECTORS_SVH
`define IFU_DEC_VECTORS_SVH

// row fields in order are inst, pc, vld, rs1 idx, rs2 idx, csr raddr, vmask, exccode,
// alu a, alu b, imm_shifted, branch offset, rf target, ops and flags
task automatic load_vectors();
   // alu register forms with rd 3 rj 4 rk 5
   tbl[0]  = '{32'h00101483, 32'h1c000000, 1'b1, 5'd4, 5'd5, 14'h0405, 6'b100000, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h00, 8'h00};
   tbl[1]  = '{32'h00111483, 32'h1c000004, 1'b1, 5'd4, 5'd5, 14'h0445, 6'b100000, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h10, 8'h00};
   tbl[2]  = '{32'h00121483, 32'h1c000008, 1'b1, 5'd4, 5'd5, 14'h0485, 6'b100000, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h50, 8'h00};
   tbl[3]  = '{32'h00129483, 32'h1c00000c, 1'b1, 5'd4, 5'd5, 14'h04a5, 6'b100000, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h60, 8'h00};
   tbl[4]  = '{32'h00149483, 32'h1c000010, 1'b1, 5'd4, 5'd5, 14'h0525, 6'b100000, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h20, 8'h00};
   tbl[5]  = '{32'h00151483, 32'h1c000014, 1'b1, 5'd4, 5'd5, 14'h0545, 6'b100000, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h30, 8'h00};
   tbl[6]  = '{32'h00159483, 32'h1c000018, 1'b1, 5'd4, 5'd5, 14'h0565, 6'b100000, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h40, 8'h00};
   // alu immediate forms
   tbl[7]  = '{32'h02bff083, 32'h1c00001c, 1'b1, 5'd4, 5'd28, 14'h2ffc, 6'b100000, 6'h00,
               RS1, 32'hfffffffc, 32'hfffffffc, 32'h0, 5'd3, 8'h00, 8'h80};
   tbl[8]  = '{32'h03600083, 32'h1c000020, 1'b1, 5'd4, 5'd0, 14'h1800, 6'b100000, 6'h00,
               RS1, 32'h00000800, 32'h00000800, 32'h0, 5'd3, 8'h20, 8'h80};
   tbl[9]  = '{32'h03848c83, 32'h1c000024, 1'b1, 5'd4, 5'd3, 14'h2123, 6'b100000, 6'h00,
               RS1, 32'h00000123, 32'h00000123, 32'h0, 5'd3, 8'h30, 8'h80};
   tbl[10] = '{32'h15579bc3, 32'h1c000028, 1'b1, 5'd30, 5'd6, 14'h15e6, 6'b100000, 6'h00,
               RS1, 32'habcde000, 32'habcde000, 32'h0, 5'd3, 8'h70, 8'h80};
   tbl[11] = '{32'h1c000023, 32'h1c00002c, 1'b1, 5'd1, 5'd0, 14'h0000, 6'b100000, 6'h00,
               32'h1c00002c, 32'h00001000, 32'h00001000, 32'h0, 5'd3, 8'h00, 8'h80};
   // loads and stores
   tbl[12] = '{32'h28804083, 32'h1c000030, 1'b1, 5'd4, 5'd16, 14'h2010, 6'b010000, 6'h00,
               RS1, RS2, 32'h00000010, 32'h0, 5'd3, 8'h00, 8'h40};
   tbl[13] = '{32'h2a200483, 32'h1c000034, 1'b1, 5'd4, 5'd1, 14'h0801, 6'b010000, 6'h00,
               RS1, RS2, 32'hfffff801, 32'h0, 5'd3, 8'h04, 8'h40};
   tbl[14] = '{32'h29808083, 32'h1c000038, 1'b1, 5'd4, 5'd3, 14'h2020, 6'b010000, 6'h00,
               RS1, RS2, 32'h00000020, 32'h0, 5'd3, 8'h08, 8'h00};
   tbl[15] = '{32'h291ffc83, 32'h1c00003c, 1'b1, 5'd4, 5'd3, 14'h07ff, 6'b010000, 6'h00,
               RS1, RS2, 32'h000007ff, 32'h0, 5'd3, 8'h0c, 8'h00};
   // branches
   tbl[16] = '{32'h5bfff883, 32'h1c000040, 1'b1, 5'd4, 5'd3, 14'h3ffe, 6'b001000, 6'h00,
               RS1, RS2, 32'h0, 32'hfffffff8, 5'd3, 8'h00, 8'h00};
   tbl[17] = '{32'h5c001083, 32'h1c000044, 1'b1, 5'd4, 5'd3, 14'h0004, 6'b001000, 6'h00,
               RS1, RS2, 32'h0, 32'h00000010, 5'd3, 8'h01, 8'h00};
   tbl[18] = '{32'h500403ff, 32'h1c000048, 1'b1, 5'd31, 5'd0, 14'h0100, 6'b001000, 6'h00,
               RS1, RS2, 32'h0, 32'hfffc0400, 5'd31, 8'h02, 8'h00};
   tbl[19] = '{32'h54010000, 32'h1c00004c, 1'b1, 5'd0, 5'd0, 14'h0040, 6'b001000, 6'h00,
               RS1, RS2, 32'h0, 32'h00000100, 5'd1, 8'h03, 8'h00};
   // multiplies
   tbl[20] = '{32'h001c1483, 32'h1c000050, 1'b1, 5'd4, 5'd5, 14'h0705, 6'b000100, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h00, 8'h30};
   tbl[21] = '{32'h001c9483, 32'h1c000054, 1'b1, 5'd4, 5'd5, 14'h0725, 6'b000100, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h00, 8'h38};
   tbl[22] = '{32'h001d1483, 32'h1c000058, 1'b1, 5'd4, 5'd5, 14'h0745, 6'b000100, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h00, 8'h28};
   // csr access and ertn
   tbl[23] = '{32'h04001403, 32'h1c00005c, 1'b1, 5'd0, 5'd5, 14'h0005, 6'b000010, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h00, 8'h04};
   tbl[24] = '{32'h04001823, 32'h1c000060, 1'b1, 5'd1, 5'd3, 14'h0006, 6'b000010, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h00, 8'h05};
   tbl[25] = '{32'h04060083, 32'h1c000064, 1'b1, 5'd4, 5'd3, 14'h0180, 6'b000010, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h00, 8'h07};
   tbl[26] = '{32'h06483800, 32'h1c000068, 1'b1, 5'd0, 5'd14, 14'h120e, 6'b000001, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd0, 8'h00, 8'h00};
   // traps and then a killed slot
   tbl[27] = '{32'h002b0000, 32'h1c00006c, 1'b1, 5'd0, 5'd0, 14'h0ac0, 6'b000000, 6'h0b,
               RS1, RS2, 32'h0, 32'h0, 5'd0, 8'h00, 8'h00};
   tbl[28] = '{32'h002a0005, 32'h1c000070, 1'b1, 5'd0, 5'd0, 14'h0a80, 6'b000000, 6'h0c,
               RS1, RS2, 32'h0, 32'h0, 5'd5, 8'h00, 8'h00};
   tbl[29] = '{32'hffffffff, 32'h1c000074, 1'b1, 5'd31, 5'd31, 14'h3fff, 6'b000000, 6'h0d,
               RS1, RS2, 32'h0, 32'h0, 5'd31, 8'h00, 8'h00};
   tbl[30] = '{32'h00101483, 32'h1c000078, 1'b0, 5'd4, 5'd5, 14'h0405, 6'b000000, 6'h00,
               RS1, RS2, 32'h0, 32'h0, 5'd3, 8'h00, 8'h00};
endtask

`endif

// File: sim/tb_ifu_dec.sv
`default_nettype none

module tb_ifu_dec;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ROWS       = 31;
   localparam int RST_CYCLES = 4;
   localparam int MAX_CYCLES = 2 * (ROWS + RST_CYCLES) + 20;

   // register file read data used by every row
   localparam logic [31:0] RS1 = 32'h1234_5678;
   localparam logic [31:0] RS2 = 32'h8765_4321;

   // vmask  {alu wen, lsu valid, bru valid, mul valid, csr valid, ertn valid}
   // ops    {alu op[3:0], lsu op[1:0], bru op[1:0]}
   // flags  {b_imm, lsu wen, mul wen, mul signed, mul hi, csr rdwen, csr xchg, csr wen}
   typedef struct packed {
      logic [31:0] inst;
      logic [31:0] pc;
      logic        vld;
      logic [4:0]  rs1i;
      logic [4:0]  rs2i;
      logic [13:0] craddr;
      logic [5:0]  vmask;
      logic [5:0]  exc;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] offs;
      logic [4:0]  rft;
      logic [7:0]  ops;
      logic [7:0]  flags;
   } row_t;

   logic              clk;
   logic              rst;
   dec_pkg::word_t    inst_d;
   dec_pkg::word_t    pc_d;
   logic              inst_vld_d;
   dec_pkg::word_t    rs1_data_d;
   dec_pkg::word_t    rs2_data_d;
   dec_pkg::rs_idx_t  rs_idx_d;
   dec_pkg::csr_idx_t csr_raddr_d;
   dec_pkg::d2e_t     ex_e;

   row_t   tbl [ROWS];
   int     order [ROWS];
   int     cycles;
   integer seed;

   `include "ifu_dec_vectors.svh"

   ifu_dec uut (
      .clk         (clk),
      .rst         (rst),
      .inst_d      (inst_d),
      .pc_d        (pc_d),
      .inst_vld_d  (inst_vld_d),
      .rs1_data_d  (rs1_data_d),
      .rs2_data_d  (rs2_data_d),
      .rs_idx_d    (rs_idx_d),
      .csr_raddr_d (csr_raddr_d),
      .ex_e        (ex_e)
   );

   always #2 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TB FAILED");
         $fatal(1, "timeout");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic apply_row(input int i);
      inst_d     = tbl[i].inst;
      pc_d       = tbl[i].pc;
      inst_vld_d = tbl[i].vld;
      rs1_data_d = RS1;
      rs2_data_d = RS2;
   endtask

   task automatic verify_reset_state();
      check("reset unit valids",
            32'({ex_e.alu.wen, ex_e.lsu.valid, ex_e.bru.valid, ex_e.mul.valid,
                 ex_e.csr.valid, ex_e.ertn_valid}), 32'h0);
      check("reset exception", 32'(ex_e.exc.exception), 32'h0);
      check("reset enables",
            32'({ex_e.alu.b_imm, ex_e.lsu.wen, ex_e.mul.wen, ex_e.csr.rdwen,
                 ex_e.csr.xchg, ex_e.csr.wen}), 32'h0);
   endtask

   task automatic check_decode(input int i);
      check("rs1 index", 32'(rs_idx_d.rs1), 32'(tbl[i].rs1i));
      check("rs2 index", 32'(rs_idx_d.rs2), 32'(tbl[i].rs2i));
      check("csr read address", 32'(csr_raddr_d), 32'(tbl[i].craddr));
   endtask

   task automatic check_execute(input int i);
      logic [5:0] vmask;
      logic [7:0] flags;
      logic [7:0] fmask;
      vmask = {ex_e.alu.wen, ex_e.lsu.valid, ex_e.bru.valid, ex_e.mul.valid,
               ex_e.csr.valid, ex_e.ertn_valid};
      flags = {ex_e.alu.b_imm, ex_e.lsu.wen, ex_e.mul.wen, ex_e.mul.is_signed,
               ex_e.mul.hi, ex_e.csr.rdwen, ex_e.csr.xchg, ex_e.csr.wen};
      // multiplier sign and half only matter on a multiply
      fmask = tbl[i].vmask[2] ? 8'hff : 8'he7;
      check("unit valids", 32'(vmask), 32'(tbl[i].vmask));
      check("exception", 32'(ex_e.exc.exception), 32'(tbl[i].exc != 6'h00));
      check("exccode", 32'(ex_e.exc.exccode), 32'(tbl[i].exc));
      check("alu a", ex_e.alu.a, tbl[i].a);
      check("alu b", ex_e.alu.b, tbl[i].b);
      check("imm_shifted", ex_e.lsu.imm_shifted, tbl[i].imm);
      check("branch offset", ex_e.bru.offset, tbl[i].offs);
      check("rf target", 32'(ex_e.rf_target), 32'(tbl[i].rft));
      check("lsu rd", 32'(ex_e.lsu.rd), 32'(tbl[i].rft));
      check("ops", 32'({ex_e.alu.op, ex_e.lsu.op, ex_e.bru.op}), 32'(tbl[i].ops));
      check("flags", 32'(flags & fmask), 32'(tbl[i].flags & fmask));
      check("csr waddr", 32'(ex_e.csr.waddr), 32'(tbl[i].craddr));
      check("execute rs1", 32'(ex_e.rs_idx.rs1), 32'(tbl[i].rs1i));
      check("execute rs2", 32'(ex_e.rs_idx.rs2), 32'(tbl[i].rs2i));
   endtask

   // one row per cycle with each result checked while the next row decodes
   task automatic run_pass();
      for (int k = 0; k < ROWS; k++) begin
         @(negedge clk);
         if (k > 0) begin
            check_execute(order[k-1]);
         end
         apply_row(order[k]);
         #1;
         check_decode(order[k]);
      end
      @(negedge clk);
      check_execute(order[ROWS-1]);
      inst_vld_d = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int j;
      int t;
      int rst_rows [RST_CYCLES];
      clk        = 1'b0;
      rst        = 1'b1;
      inst_d     = '0;
      pc_d       = '0;
      inst_vld_d = 1'b0;
      rs1_data_d = '0;
      rs2_data_d = '0;
      cycles     = 0;
      seed       = 32'he0948063;
      load_vectors();

      // live words sit in decode while reset holds the stage empty
      rst_rows = '{7, 12, 25, 27};
      for (int c = 0; c < RST_CYCLES; c++) begin
         apply_row(rst_rows[c]);
         @(negedge clk);
         verify_reset_state();
      end
      rst = 1'b0;

      // table order
      for (int k = 0; k < ROWS; k++) begin
         order[k] = k;
      end
      run_pass();

      // shuffled back to back replay
      for (int k = ROWS - 1; k > 0; k--) begin
         j        = int'($unsigned($random(seed)) % (k + 1));
         t        = order[k];
         order[k] = order[j];
         order[j] = t;
      end
      run_pass();

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
rtl/dec_pkg.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/dispatch_ctrl.sv
rtl/d2e_reg.sv
rtl/ifu_dec.sv
sim/tb_ifu_dec.sv

// File: run_sim.sh
#!/bin/sh
# build the decode stage testbench, run it, then scan the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_ifu_dec \
   -o tb_ifu_dec > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_ifu_dec > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
